// ==== Bender.yml ====
package:
  name: mul

sources:
  - include_dirs:
      - .
    files:
      - mulPkg.sv
      - csaColumn.sv
      - boothDecode.sv
      - wallaceTree.sv
      - productSelect.sv
      - mulTop.sv
  - target: test
    include_dirs:
      - .
    files:
      - tbMul.sv

// ==== boothDecode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mul_macros.svh"

module boothDecode (
    input  wire                Clk,
    input  wire                rstN,
    input  wire mulPkg::mulReqT req,
    output mulPkg::ppBundleT   ppBundle
);

    logic                                         signExt;
    logic [`MUL_EXT_WIDTH-1:0]                    mcandExt;
    // multiplier with the implicit zero below bit 0
    logic [`MUL_EXT_WIDTH:0]                      mplierExt;
    logic [`MUL_COL_WIDTH-1:0]                    mcandOne;
    logic [`MUL_COL_WIDTH-1:0]                    mcandTwo;
    logic [`MUL_PP_ROWS-1:0][`MUL_COL_WIDTH-1:0] rowsNext;

    logic                                         validQ;
    mulPkg::mulOpE                                opQ;
    logic [`MUL_TAG_WIDTH-1:0]                    tagQ;
    logic [`MUL_PP_ROWS-1:0][`MUL_COL_WIDTH-1:0] rowsQ;

    // only the unsigned high multiply zero-extends
    assign signExt = (req.op != mulPkg::mulhWu);

    assign mcandExt = {{(`MUL_EXT_WIDTH-`MUL_WIDTH){signExt & req.multiplicand[`MUL_WIDTH-1]}},
                       req.multiplicand};
    assign mplierExt = {{(`MUL_EXT_WIDTH-`MUL_WIDTH){signExt & req.multiplier[`MUL_WIDTH-1]}},
                        req.multiplier, 1'b0};

    // +1x and +2x, sign-extended to full row width
    assign mcandOne = {{(`MUL_COL_WIDTH-`MUL_EXT_WIDTH){mcandExt[`MUL_EXT_WIDTH-1]}}, mcandExt};
    assign mcandTwo = {mcandOne[`MUL_COL_WIDTH-2:0], 1'b0};

    always_comb begin : boothRows
        logic [2:0]                grp;
        logic [`MUL_COL_WIDTH-1:0] mag;
        logic [`MUL_PP_ROWS-1:0]   digitNeg;
        for (int i = 0; i < `MUL_PP_ROWS; i++) begin
            grp = mplierExt[2*i +: 3];
            // digit magnitude from the overlapping group
            case (grp)
                3'b001, 3'b010, 3'b101, 3'b110: mag = mcandOne;
                3'b011, 3'b100:                 mag = mcandTwo;
                default:                        mag = '0;
            endcase
            // 111 is minus zero, kept positive
            digitNeg[i] = grp[2] & ~(grp[1] & grp[0]);
            // complement before the shift so the low bits stay zero
            if (digitNeg[i]) begin
                mag = ~mag;
            end
            rowsNext[i] = mag << (2 * i);
            // +1 of the previous row sits in this row's free low bits
            if (i > 0) begin
                rowsNext[i][2*i-2] = digitNeg[i-1];
            end
        end
        // top group is 000, 111 or 001 after extension, so no 18th row
    end

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            validQ <= 1'b0;
        end else begin
            validQ <= req.valid;
        end
    end

    // payload only moves with a request
    always_ff @(posedge Clk) begin
        if (req.valid) begin
            opQ   <= req.op;
            tagQ  <= req.tag;
            rowsQ <= rowsNext;
        end
    end

    assign ppBundle = '{valid: validQ, op: opQ, tag: tagQ, rows: rowsQ};

endmodule

`default_nettype wire

// ==== csaColumn.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mul_macros.svh"

module csaColumn (
    input  wire [`MUL_PP_ROWS-1:0]     rowBits,
    input  wire [`MUL_CSA_CARRIES-1:0] carryIn,
    output logic [`MUL_CSA_CARRIES-1:0] carryOut,
    output logic                        carry,
    output logic                        sum
);

    // fifteen full adders, one bit per adder
    logic [`MUL_CSA_CARRIES:0] faA;
    logic [`MUL_CSA_CARRIES:0] faB;
    logic [`MUL_CSA_CARRIES:0] faC;
    logic [`MUL_CSA_CARRIES:0] faSum;
    logic [`MUL_CSA_CARRIES:0] faCarry;

    // full adder equations, all adders at once
    assign faSum   = faA ^ faB ^ faC;
    assign faCarry = (faA & faB) | (faB & faC) | (faA & faC);

    // level 1, fifteen row bits into five adders
    assign {faA[0], faB[0], faC[0]} = {rowBits[2], rowBits[3], rowBits[4]};
    assign {faA[1], faB[1], faC[1]} = {rowBits[5], rowBits[6], rowBits[7]};
    assign {faA[2], faB[2], faC[2]} = {rowBits[8], rowBits[9], rowBits[10]};
    assign {faA[3], faB[3], faC[3]} = {rowBits[11], rowBits[12], rowBits[13]};
    assign {faA[4], faB[4], faC[4]} = {rowBits[14], rowBits[15], rowBits[16]};

    // level 2, early carries from the column below join here
    assign {faA[5], faB[5], faC[5]} = {carryIn[0], carryIn[1], carryIn[2]};
    assign {faA[6], faB[6], faC[6]} = {rowBits[0], carryIn[3], carryIn[4]};
    assign {faA[7], faB[7], faC[7]} = {rowBits[1], faSum[0], faSum[1]};
    assign {faA[8], faB[8], faC[8]} = {faSum[2], faSum[3], faSum[4]};

    // level 3
    assign {faA[9], faB[9], faC[9]}    = {faSum[5], carryIn[5], carryIn[6]};
    assign {faA[10], faB[10], faC[10]} = {faSum[6], faSum[7], faSum[8]};

    // level 4
    assign {faA[11], faB[11], faC[11]} = {carryIn[7], carryIn[8], carryIn[9]};
    assign {faA[12], faB[12], faC[12]} = {faSum[9], faSum[10], carryIn[10]};

    // level 5
    assign {faA[13], faB[13], faC[13]} = {faSum[11], faSum[12], carryIn[11]};

    // last adder takes the latest carries
    assign {faA[14], faB[14], faC[14]} = {faSum[13], carryIn[12], carryIn[13]};

    // carries of adders 0..13 feed the same adders one column up
    assign carryOut = faCarry[`MUL_CSA_CARRIES-1:0];
    assign carry    = faCarry[`MUL_CSA_CARRIES];
    assign sum      = faSum[`MUL_CSA_CARRIES];

endmodule

`default_nettype wire

// ==== mulPkg.sv ====
`default_nettype none

`include "mul_macros.svh"

package mulPkg;

    // multiply flavours, code 3 is unused and yields zero
    typedef enum logic [1:0] {
        mulW      = 2'b00,
        mulhW     = 2'b01,
        mulhWu    = 2'b10,
        mulUnused = 2'b11
    } mulOpE;

    // request as sampled from the issue side
    typedef struct packed {
        logic                      valid;
        mulOpE                     op;
        logic [`MUL_TAG_WIDTH-1:0] tag;
        logic [`MUL_WIDTH-1:0]     multiplicand;
        logic [`MUL_WIDTH-1:0]     multiplier;
    } mulReqT;

    // stage one register, rows already shifted into place
    typedef struct packed {
        logic                                         valid;
        mulOpE                                        op;
        logic [`MUL_TAG_WIDTH-1:0]                    tag;
        logic [`MUL_PP_ROWS-1:0][`MUL_COL_WIDTH-1:0] rows;
    } ppBundleT;

    // redundant form out of the carry-save tree
    typedef struct packed {
        logic [`MUL_COL_WIDTH-1:0] sum;
        logic [`MUL_COL_WIDTH-1:0] carry;
    } treeSumT;

    typedef struct packed {
        logic [`MUL_WIDTH-1:0] hi;
        logic [`MUL_WIDTH-1:0] lo;
    } productHalvesT;

    // 64-bit product, read whole or by half
    typedef union packed {
        logic [2*`MUL_WIDTH-1:0] word;
        productHalvesT           half;
    } productU;

    typedef struct packed {
        logic                      valid;
        logic [`MUL_TAG_WIDTH-1:0] tag;
        logic [`MUL_WIDTH-1:0]     result;
    } mulRespT;

endpackage

`default_nettype wire

// ==== mulTop.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mul_macros.svh"

module mulTop (
    input  wire                Clk,
    input  wire                rstN,
    input  wire mulPkg::mulReqT req,
    output mulPkg::mulRespT    resp
);

    // stage one register, read by both the tree and the result stage
    mulPkg::ppBundleT ppBundle;
    // combinational tree output
    mulPkg::treeSumT  treeSum;

    // decode: booth rows, registered
    boothDecode i_boothDecode (
        .Clk      (Clk),
        .rstN     (rstN),
        .req      (req),
        .ppBundle (ppBundle)
    );

    // execute: carry-save reduction to two vectors
    wallaceTree i_wallaceTree (
        .ppBundle (ppBundle),
        .treeSum  (treeSum)
    );

    // result: final add, word select, output register
    productSelect i_productSelect (
        .Clk      (Clk),
        .rstN     (rstN),
        .ppBundle (ppBundle),
        .treeSum  (treeSum),
        .resp     (resp)
    );

endmodule

`default_nettype wire

// ==== mul_golden.txt ====
// columns: op (0 mulW, 1 mulhW, 2 mulhWu, 3 unused), tag, multiplicand, multiplier, result
// all values hex, one operation per line
0 01 00000003 00000005 0000000F
0 02 FFFFFFFF FFFFFFFF 00000001
0 03 00000000 12345678 00000000
0 04 FFFFFFFE 00000003 FFFFFFFA
0 05 00010000 00010000 00000000
0 06 7FFFFFFF 00000002 FFFFFFFE
0 07 12345678 00000010 23456780
0 08 FFFFFFFF 00000007 FFFFFFF9
1 09 80000000 80000000 40000000
1 0A FFFFFFFF 00000005 FFFFFFFF
1 0B 80000000 00000002 FFFFFFFF
1 0C 7FFFFFFF 7FFFFFFF 3FFFFFFF
1 0D FFFFFFFF FFFFFFFF 00000000
1 0E 00010000 00010000 00000001
1 0F FFFF0000 00010000 FFFFFFFF
1 10 80000000 7FFFFFFF C0000000
2 11 FFFFFFFF FFFFFFFF FFFFFFFE
2 12 80000000 80000000 40000000
2 13 80000000 00000002 00000001
2 14 FFFFFFFF 00000005 00000004
2 15 00010000 00010000 00000001
3 16 12345678 9ABCDEF0 00000000
0 17 00001234 00005678 06260060
3 18 FFFFFFFF FFFFFFFF 00000000
1 19 FFFFFFF0 00000010 FFFFFFFF
2 1A FFFFFFF0 00000010 0000000F
0 1B 80000000 FFFFFFFF 80000000
1 1C 80000000 FFFFFFFF 00000000
2 1D 80000000 FFFFFFFF 7FFFFFFF
3 1E 00000001 00000001 00000000
1 1F 00000003 FFFFFFFD FFFFFFFF
0 00 00000003 FFFFFFFD FFFFFFF7
2 01 00000003 FFFFFFFD 00000002
0 02 0000FFFF 0000FFFF FFFE0001
1 03 0000FFFF 0000FFFF 00000000
2 04 ABCDEF01 00000001 00000000
1 05 ABCDEF01 00000001 FFFFFFFF

// ==== mul_macros.svh ====
`ifndef MUL_MACROS_SVH
`define MUL_MACROS_SVH

// operand and result width
`define MUL_WIDTH 32

// operand after sign or zero extension, even so it splits into 17 booth digits
`define MUL_EXT_WIDTH 34

// one partial-product row per radix-4 digit
`define MUL_PP_ROWS 17

// row width, also the full product width inside the tree
`define MUL_COL_WIDTH 68

// carries passed from one tree column to the next
`define MUL_CSA_CARRIES 14

// destination register tag
`define MUL_TAG_WIDTH 5

`endif

// ==== productSelect.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mul_macros.svh"

module productSelect (
    input  wire                  Clk,
    input  wire                  rstN,
    input  wire mulPkg::ppBundleT ppBundle,
    input  wire mulPkg::treeSumT  treeSum,
    output mulPkg::mulRespT      resp
);

    mulPkg::productU       product;
    logic [`MUL_WIDTH-1:0] resultNext;

    // carry-propagate add, only the low 64 bits matter
    assign product.word = treeSum.sum[2*`MUL_WIDTH-1:0]
                        + {treeSum.carry[2*`MUL_WIDTH-2:0], 1'b0};

    // word select follows the op that travelled with the rows
    always_comb begin
        case (ppBundle.op)
            mulPkg::mulW:   resultNext = product.half.lo;
            mulPkg::mulhW:  resultNext = product.half.hi;
            mulPkg::mulhWu: resultNext = product.half.hi;
            default:        resultNext = '0;
        endcase
    end

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            resp <= '0;
        end else begin
            resp.valid <= ppBundle.valid;
            // hold the last result between operations
            if (ppBundle.valid) begin
                resp.tag    <= ppBundle.tag;
                resp.result <= resultNext;
            end
        end
    end

endmodule

`default_nettype wire

// ==== tbMul.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mul_macros.svh"

module tbMul;

    // five hex words per golden entry
    localparam int maxEntries    = 64;
    localparam int wordsPerEntry = 5;
    // entries from this index on run after the second reset
    localparam int resetEntry    = 21;
    localparam int drainLimit    = 20;
    localparam int latency       = 2;

    // one outstanding request
    typedef struct packed {
        int idx;
        int issueCycle;
    } pendingT;

    logic            Clk;
    logic            rstN;
    mulPkg::mulReqT  req;
    mulPkg::mulRespT resp;

    logic [`MUL_WIDTH-1:0] goldenMem [0:maxEntries*wordsPerEntry-1];
    int                    numEntries;
    int                    cycleCount = 0;
    pendingT               pending [$];
    logic [15:0]           lfsrState;
    int                    valueErrors  = 0;
    int                    timingErrors = 0;
    int                    otherErrors  = 0;

    mulTop i_mulTop (
        .Clk  (Clk),
        .rstN (rstN),
        .req  (req),
        .resp (resp)
    );

    initial begin
        Clk = 1'b0;
        forever #5 Clk = ~Clk;
    end

    // rising edges seen so far
    always @(posedge Clk) begin
        cycleCount <= cycleCount + 1;
    end

    // taps 16,14,13,11
    function automatic logic [15:0] lfsrNext(input logic [15:0] state);
        logic fb;
        fb = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], fb};
    endfunction

    // one step per bit taken
    function automatic logic nextRandomBit();
        lfsrState = lfsrNext(lfsrState);
        return lfsrState[0];
    endfunction

    // outputs must sit at their reset values
    task automatic checkQuiet(input string phase);
        if (resp.valid !== 1'b0) begin
            valueErrors++;
            $display("FAIL resp.valid %s: expected 0x0, got 0x%0h", phase, resp.valid);
        end
        if (resp.result !== '0) begin
            valueErrors++;
            $display("FAIL resp.result %s: expected 0x00000000, got 0x%08h", phase, resp.result);
        end
        if (resp.tag !== '0) begin
            valueErrors++;
            $display("FAIL resp.tag %s: expected 0x00, got 0x%02h", phase, resp.tag);
        end
    endtask

    task automatic checkResponse();
        pendingT                   p;
        int                        base;
        logic [`MUL_WIDTH-1:0]     expResult;
        logic [`MUL_TAG_WIDTH-1:0] expTag;
        if (pending.size() == 0) begin
            otherErrors++;
            $display("response at cycle %0d with no request outstanding", cycleCount);
        end else begin
            p         = pending.pop_front();
            base      = p.idx * wordsPerEntry;
            expTag    = goldenMem[base+1][`MUL_TAG_WIDTH-1:0];
            expResult = goldenMem[base+4];
            if (resp.result !== expResult) begin
                valueErrors++;
                $display("FAIL resp.result entry %0d: expected 0x%08h, got 0x%08h",
                         p.idx, expResult, resp.result);
            end
            if (resp.tag !== expTag) begin
                valueErrors++;
                $display("FAIL resp.tag entry %0d: expected 0x%02h, got 0x%02h",
                         p.idx, expTag, resp.tag);
            end
            // sampled at the edge after issue and registered at the one after that
            if (cycleCount != p.issueCycle + latency) begin
                timingErrors++;
                $display("entry %0d arrived at cycle %0d instead of cycle %0d",
                         p.idx, cycleCount, p.issueCycle + latency);
            end
        end
    endtask

    // outputs are stable at the falling edge
    always @(negedge Clk) begin
        if (rstN === 1'b1 && resp.valid === 1'b1) begin
            checkResponse();
        end
    end

    task automatic driveRequest(input int idx);
        int      base;
        pendingT entry;
        base             = idx * wordsPerEntry;
        req.valid        = 1'b1;
        req.op           = mulPkg::mulOpE'(goldenMem[base][1:0]);
        req.tag          = goldenMem[base+1][`MUL_TAG_WIDTH-1:0];
        req.multiplicand = goldenMem[base+2];
        req.multiplier   = goldenMem[base+3];
        // issue cycle is the edge just passed
        entry.idx        = idx;
        entry.issueCycle = cycleCount;
        pending.push_back(entry);
    endtask

    task automatic issueRange(input int first, input int last);
        for (int i = first; i < last; i++) begin
            @(posedge Clk);
            #1;
            driveRequest(i);
            // sometimes one idle cycle before the next request
            if (nextRandomBit()) begin
                @(posedge Clk);
                #1;
                req.valid = 1'b0;
            end
        end
        @(posedge Clk);
        #1;
        req.valid = 1'b0;
    endtask

    // hold reset for 5 cycles and expect quiet outputs until a new request
    task automatic holdReset();
        @(posedge Clk);
        #1;
        rstN = 1'b0;
        req  = '0;
        repeat (5) begin
            @(negedge Clk);
            checkQuiet("in reset");
            @(posedge Clk);
        end
        #1;
        rstN = 1'b1;
        repeat (latency) begin
            @(negedge Clk);
            checkQuiet("after reset");
        end
    endtask

    task automatic waitForDrain();
        int waited;
        waited = 0;
        while (pending.size() != 0 && waited < drainLimit) begin
            @(posedge Clk);
            waited++;
        end
        if (pending.size() != 0) begin
            otherErrors++;
            $display("%0d responses went missing, none seen within %0d cycles",
                     pending.size(), drainLimit);
            pending.delete();
        end
    endtask

    initial begin
        rstN      = 1'b0;
        req       = '0;
        lfsrState = 16'd88;
        // marker words show where the file ends
        for (int i = 0; i < maxEntries * wordsPerEntry; i++) begin
            goldenMem[i] = {16'hdead, i[15:0]};
        end
        $readmemh("mul_golden.txt", goldenMem);
        numEntries = 0;
        while (numEntries < maxEntries &&
               goldenMem[numEntries*wordsPerEntry][31:16] != 16'hdead) begin
            numEntries++;
        end
        holdReset();
        if (numEntries <= resetEntry) begin
            otherErrors++;
            $display("golden file holds only %0d entries", numEntries);
        end else begin
            // mulW, mulhW, mulhWu back to back
            issueRange(0, resetEntry);
            waitForDrain();
            // second reset before the unused code and mixed ops
            holdReset();
            issueRange(resetEntry, numEntries);
            waitForDrain();
        end
        // quiet tail to catch stray responses
        repeat (4) @(posedge Clk);
        $display("errors: value %0d, timing %0d, other %0d",
                 valueErrors, timingErrors, otherErrors);
        if (valueErrors + timingErrors + otherErrors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+.
mulPkg.sv
csaColumn.sv
boothDecode.sv
wallaceTree.sv
productSelect.sv
mulTop.sv
tbMul.sv

// ==== wallaceTree.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mul_macros.svh"

module wallaceTree (
    input  wire mulPkg::ppBundleT ppBundle,
    output mulPkg::treeSumT       treeSum
);

    // entry k feeds column k, the top entry falls off the 68-bit product
    wire [`MUL_COL_WIDTH:0][`MUL_CSA_CARRIES-1:0] carryLink;
    wire [`MUL_COL_WIDTH-1:0]                     colSum;
    wire [`MUL_COL_WIDTH-1:0]                     colCarry;

    // lowest column has nothing coming in
    assign carryLink[0] = '0;

    for (genvar k = 0; k < `MUL_COL_WIDTH; k++) begin : genColumn
        wire [`MUL_PP_ROWS-1:0] colBits;

        // bit k of every row
        for (genvar r = 0; r < `MUL_PP_ROWS; r++) begin : genSlice
            assign colBits[r] = ppBundle.rows[r][k];
        end

        csaColumn i_csaColumn (
            .rowBits  (colBits),
            .carryIn  (carryLink[k]),
            .carryOut (carryLink[k+1]),
            .carry    (colCarry[k]),
            .sum      (colSum[k])
        );
    end

    // column carry still has weight k+1, shifted in the result stage
    assign treeSum = '{sum: colSum, carry: colCarry};

endmodule

`default_nettype wire
